// ==== src/pix_pkg.sv ====
package pix_pkg;

  localparam int ROWS        = 4;
  localparam int EDGE_WORDS  = 1;
  localparam int KH_MAX      = 3;
  localparam int WORD_WIDTH  = 8;
  localparam int IN_WORDS    = 4;
  localparam int GRP_WORDS   = ROWS + EDGE_WORDS;
  localparam int SHIFT_WORDS = ROWS + KH_MAX - 1;
  localparam int PK_WORDS    = GRP_WORDS + IN_WORDS - 1;

  localparam int CI_MAX  = 8;
  localparam int XW_MAX  = 8;
  localparam int BLK_MAX = 8;

  localparam int BITS_KH2 = $clog2((KH_MAX + 1) / 2);
  localparam int BITS_CI  = $clog2(CI_MAX);
  localparam int BITS_XW  = $clog2(XW_MAX);
  localparam int BITS_BLK = $clog2(BLK_MAX);
  localparam int BITS_PK  = $clog2(PK_WORDS + 1);

  localparam int RAM_DEPTH = CI_MAX * XW_MAX;
  localparam int BITS_RAM  = $clog2(RAM_DEPTH);
  localparam int CFG_BITS  = BITS_KH2 + BITS_CI + BITS_XW + BITS_BLK;

  // Config beat, kh2 sits in the lowest bits
  typedef struct packed {
    logic [BITS_BLK-1:0] blk;
    logic [BITS_XW-1:0]  w;
    logic [BITS_CI-1:0]  ci;
    logic [BITS_KH2-1:0] kh2;
  } cfg_t;

endpackage

// ==== src/pix_if.sv ====
`timescale 1ns/100ps

// Packed column groups, packer to control and shifter
interface grp_if;
  import pix_pkg::*;

  logic                                 valid;
  logic                                 ready;
  logic                                 last;
  logic [GRP_WORDS-1:0][WORD_WIDTH-1:0] data;

  modport src (output valid, last, data, input ready);
  modport ctl (input valid, last, output ready);
  modport snk (input data);
endinterface

// Strobes from the control FSM
interface ctl_if;
  import pix_pkg::*;

  logic                en_config;
  logic                en_shift;
  logic                en_copy;
  logic                copy_r;
  logic                first_r;
  logic                last_blk_r;
  logic                last_col;
  logic [BITS_KH2-1:0] kh2;

  modport ctrl (
    output en_config, en_shift, en_copy, copy_r, first_r, last_blk_r, last_col, kh2
  );
  modport shift (input en_shift, copy_r, kh2);
  modport ram (input en_config, en_copy, copy_r, first_r, last_blk_r, last_col);
endinterface

// ==== src/word_packer.sv ====
`timescale 1ns/100ps

module word_packer (
  input  logic                                                   aclk,
  input  logic                                                   aresetn,
  input  logic                                                   s_valid,
  input  logic                                                   s_last,
  input  logic [pix_pkg::IN_WORDS-1:0][pix_pkg::WORD_WIDTH-1:0] s_data,
  input  logic [pix_pkg::IN_WORDS-1:0]                           s_keep,
  output logic                                                   s_ready,
  grp_if.src                                                     grp
);
  import pix_pkg::*;

  logic [PK_WORDS-1:0][WORD_WIDTH-1:0] stage;
  logic [PK_WORDS-1:0][WORD_WIDTH-1:0] stage_nxt;
  logic [BITS_PK-1:0]                  cnt;
  logic [BITS_PK-1:0]                  cnt_nxt;
  logic                                pend_last;
  logic                                take;
  logic                                acc;

  assign take = grp.valid && grp.ready;
  assign acc  = s_valid && s_ready;

  // Room for one full input beat, and nothing more once last is seen
  assign s_ready   = !pend_last && (cnt <= BITS_PK'(PK_WORDS - IN_WORDS));
  assign grp.valid = (cnt >= BITS_PK'(GRP_WORDS)) || (pend_last && cnt != '0);
  assign grp.last  = pend_last && (cnt <= BITS_PK'(GRP_WORDS));

  // Words past the count go out as zero padding
  always_comb begin
    for (int i = 0; i < GRP_WORDS; i++) begin
      grp.data[i] = (i < int'(cnt)) ? stage[i] : '0;
    end
  end

  always_comb begin
    stage_nxt = stage;
    cnt_nxt   = cnt;
    if (take) begin
      stage_nxt = stage >> (GRP_WORDS * WORD_WIDTH);
      cnt_nxt   = (cnt > BITS_PK'(GRP_WORDS)) ? cnt - BITS_PK'(GRP_WORDS) : '0;
    end else if (acc) begin
      // Append kept words in order
      for (int i = 0; i < IN_WORDS; i++) begin
        if (s_keep[i]) begin
          stage_nxt[cnt_nxt] = s_data[i];
          cnt_nxt            = cnt_nxt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt       <= '0;
      pend_last <= 1'b0;
    end else begin
      cnt <= cnt_nxt;
      if (acc && s_last) begin
        pend_last <= 1'b1;
      end else if (take && grp.last) begin
        pend_last <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    stage <= stage_nxt;
  end

endmodule

// ==== src/pix_ctrl.sv ====
`timescale 1ns/100ps

module pix_ctrl (
  input  logic          aclk,
  input  logic          aresetn,
  input  pix_pkg::cfg_t cfg,
  input  logic          s_valid,
  input  logic          s_last,
  input  logic          s_ready_pk,
  output logic          s_ready,
  output logic          pk_valid,
  grp_if.ctl            grp,
  input  logic          m_ready,
  output logic          m_valid,
  output logic          m_last,
  ctl_if.ctrl           ctl
);
  import pix_pkg::*;

  typedef enum logic [1:0] {ST_CFG, ST_PASS, ST_DRAIN} state_t;

  state_t              state;
  cfg_t                cfg_q;
  logic [BITS_KH2:0]   kh_cnt;
  logic [BITS_KH2:0]   kh_r;
  logic [BITS_KH2:0]   kh_top;
  logic [BITS_CI-1:0]  ci_cnt;
  logic [BITS_XW-1:0]  w_cnt;
  logic [BITS_BLK-1:0] blk_cnt;
  logic                en_config, en_shift, en_copy;
  logic                kh_end, ci_end, w_end, kh_end_r, last_col;
  logic                first_blk, last_blk;
  logic                copy_r, first_r, last_blk_r, grp_last_r, last_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_CFG;
    end else begin
      case (state)
        ST_CFG:   if (s_valid) state <= ST_PASS;
        ST_PASS:  if (s_valid && s_ready_pk && s_last) state <= ST_DRAIN;
        ST_DRAIN: if (m_valid && m_ready && m_last) state <= ST_CFG;
        default:  state <= ST_CFG;
      endcase
    end
  end

  assign en_config = (state == ST_CFG);
  assign en_shift  = !en_config && m_ready;
  assign en_copy   = en_shift && grp.valid && kh_end;
  assign grp.ready = en_copy;
  assign s_ready   = en_config || ((state == ST_PASS) && s_ready_pk);
  assign pk_valid  = (state == ST_PASS) && s_valid;

  assign kh_top    = {cfg_q.kh2, 1'b0};
  assign kh_end    = (kh_cnt == kh_top);
  assign ci_end    = (ci_cnt == cfg_q.ci);
  assign w_end     = (w_cnt == cfg_q.w);
  assign last_col  = en_copy && ci_end && w_end;
  assign first_blk = (blk_cnt == '0);
  assign last_blk  = (blk_cnt == cfg_q.blk);

  // Kernel row counter parks at its end until the next group is copied
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cfg_q   <= '0;
      kh_cnt  <= '0;
      ci_cnt  <= '0;
      w_cnt   <= '0;
      blk_cnt <= '0;
    end else if (en_config) begin
      cfg_q   <= cfg;
      kh_cnt  <= {cfg.kh2, 1'b0};
      ci_cnt  <= '0;
      w_cnt   <= '0;
      blk_cnt <= '0;
    end else begin
      if (en_copy) kh_cnt <= '0;
      else if (en_shift && !kh_end) kh_cnt <= kh_cnt + 1'b1;
      if (en_copy) ci_cnt <= ci_end ? '0 : ci_cnt + 1'b1;
      if (en_copy && ci_end) w_cnt <= w_end ? '0 : w_cnt + 1'b1;
      if (last_col) blk_cnt <= blk_cnt + 1'b1;
    end
  end

  // Delay stage, lines up with edge RAM read latency
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      copy_r     <= 1'b0;
      first_r    <= 1'b0;
      last_blk_r <= 1'b0;
      grp_last_r <= 1'b0;
      kh_r       <= '0;
    end else if (en_shift) begin
      copy_r     <= en_copy;
      first_r    <= first_blk;
      last_blk_r <= last_blk;
      grp_last_r <= grp.last;
      kh_r       <= kh_cnt;
    end
  end

  assign kh_end_r = (kh_r == kh_top);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid <= 1'b0;
      last_q  <= 1'b0;
    end else if (en_shift) begin
      if (copy_r) begin
        m_valid <= 1'b1;
        last_q  <= grp_last_r;
      end else if (kh_end_r) begin
        m_valid <= 1'b0;
      end
    end
  end

  assign m_last = m_valid && last_q && kh_end_r;

  assign ctl.en_config  = en_config;
  assign ctl.en_shift   = en_shift;
  assign ctl.en_copy    = en_copy;
  assign ctl.copy_r     = copy_r;
  assign ctl.first_r    = first_r;
  assign ctl.last_blk_r = last_blk_r;
  assign ctl.last_col   = last_col;
  assign ctl.kh2        = cfg_q.kh2;

endmodule

// ==== src/edge_ram.sv ====
`timescale 1ns/100ps

module edge_ram (
  input  logic                           aclk,
  input  logic                           aresetn,
  ctl_if.ram                             ctl,
  input  logic [pix_pkg::WORD_WIDTH-1:0] edge_bot,
  output logic [pix_pkg::WORD_WIDTH-1:0] edge_top
);
  import pix_pkg::*;

  logic [WORD_WIDTH-1:0] mem [RAM_DEPTH];
  logic [BITS_RAM-1:0]   addr;
  logic [BITS_RAM-1:0]   wr_addr;
  logic [WORD_WIDTH-1:0] rd_hold;
  logic                  first_pass;
  logic                  ren;
  logic                  wen;

  assign ren = ctl.en_copy && !first_pass;
  assign wen = ctl.copy_r && !ctl.last_blk_r;

  // One entry per channel-column group of a block
  always_ff @(posedge aclk) begin
    if (!aresetn || ctl.en_config) begin
      addr       <= '0;
      first_pass <= 1'b1;
    end else if (ctl.last_col) begin
      addr       <= '0;
      first_pass <= 1'b0;
    end else if (ctl.en_copy) begin
      addr <= addr + 1'b1;
    end
  end

  // Write lands one stage after the copy
  always_ff @(posedge aclk) begin
    if (ctl.en_copy) wr_addr <= addr;
  end

  // Read data holds until the next read; same-address write is forwarded
  always_ff @(posedge aclk) begin
    if (wen) mem[wr_addr] <= edge_bot;
    if (ren) rd_hold <= (wen && wr_addr == addr) ? edge_bot : mem[addr];
  end

  assign edge_top = ctl.first_r ? '0 : rd_hold;

endmodule

// ==== src/row_shifter.sv ====
`timescale 1ns/100ps

module row_shifter (
  input  logic                                               aclk,
  input  logic                                               aresetn,
  grp_if.snk                                                 grp,
  ctl_if.shift                                               ctl,
  input  logic [pix_pkg::WORD_WIDTH-1:0]                     edge_top,
  output logic [pix_pkg::WORD_WIDTH-1:0]                     edge_bot,
  output logic [pix_pkg::ROWS-1:0][pix_pkg::WORD_WIDTH-1:0] m_data
);
  import pix_pkg::*;

  logic [GRP_WORDS-1:0][WORD_WIDTH-1:0]   data_r;
  logic [SHIFT_WORDS-1:0][WORD_WIDTH-1:0] win;

  // Group data, one stage behind the copy
  always_ff @(posedge aclk) begin
    if (ctl.en_shift) data_r <= grp.data;
  end

  // Bottom row of this group becomes the next block's top edge
  assign edge_bot = data_r[ROWS-EDGE_WORDS];

  // Window is edge word then group words, word 0 at the bottom
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      win <= '0;
    end else if (ctl.en_shift) begin
      if (ctl.copy_r) begin
        win <= {data_r, edge_top};
      end else begin
        win <= win >> WORD_WIDTH;
      end
    end
  end

  // kh2 of 0 skips the edge word
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      m_data[r] = win[r + EDGE_WORDS - int'(ctl.kh2)];
    end
  end

endmodule

// ==== src/pixel_stream_top.sv ====
`timescale 1ns/100ps

module pixel_stream_top (
  input  logic                                                   aclk,
  input  logic                                                   aresetn,
  input  logic                                                   s_valid,
  output logic                                                   s_ready,
  input  logic                                                   s_last,
  input  logic [pix_pkg::IN_WORDS-1:0][pix_pkg::WORD_WIDTH-1:0] s_data,
  input  logic [pix_pkg::IN_WORDS-1:0]                           s_keep,
  output logic                                                   m_valid,
  input  logic                                                   m_ready,
  output logic [pix_pkg::ROWS-1:0][pix_pkg::WORD_WIDTH-1:0]     m_data,
  output logic                                                   m_last
);
  import pix_pkg::*;

  logic [IN_WORDS*WORD_WIDTH-1:0] s_flat;
  cfg_t                           cfg;
  logic                           pk_valid;
  logic                           pk_ready;
  logic [WORD_WIDTH-1:0]          edge_top;
  logic [WORD_WIDTH-1:0]          edge_bot;

  grp_if grp ();
  ctl_if ctl ();

  assign s_flat = s_data;
  assign cfg    = cfg_t'(s_flat[CFG_BITS-1:0]);

  word_packer word_packer_inst (
    .aclk (aclk), .aresetn (aresetn),
    .s_valid (pk_valid), .s_last (s_last), .s_data (s_data), .s_keep (s_keep),
    .s_ready (pk_ready), .grp (grp.src)
  );

  pix_ctrl pix_ctrl_inst (
    .aclk (aclk), .aresetn (aresetn), .cfg (cfg),
    .s_valid (s_valid), .s_last (s_last), .s_ready_pk (pk_ready), .s_ready (s_ready),
    .pk_valid (pk_valid), .grp (grp.ctl),
    .m_ready (m_ready), .m_valid (m_valid), .m_last (m_last), .ctl (ctl.ctrl)
  );

  edge_ram edge_ram_inst (
    .aclk (aclk), .aresetn (aresetn), .ctl (ctl.ram),
    .edge_bot (edge_bot), .edge_top (edge_top)
  );

  row_shifter row_shifter_inst (
    .aclk (aclk), .aresetn (aresetn), .grp (grp.snk), .ctl (ctl.shift),
    .edge_top (edge_top), .edge_bot (edge_bot), .m_data (m_data)
  );

endmodule

// ==== sim/pixel_stream_chk.sv ====
`timescale 1ns/100ps

module pixel_stream_chk (
  input logic                                               aclk,
  input logic                                               aresetn,
  input logic                                               s_ready,
  input logic                                               m_valid,
  input logic                                               m_ready,
  input logic [pix_pkg::ROWS-1:0][pix_pkg::WORD_WIDTH-1:0] m_data
);
  int   fail_cnt = 0;
  logic rst_q;

  always_ff @(posedge aclk) begin
    rst_q <= !aresetn;
  end

  // Stalled output beat stays put
  assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
  else begin
    $error("m_valid or m_data changed while m_ready was low");
    fail_cnt++;
  end

  assert property (@(posedge aclk) $rose(aresetn) |-> s_ready)
  else begin
    $error("s_ready low in the first cycle after reset");
    fail_cnt++;
  end

  // Skip the first edge, registers are not reset yet
  assert property (@(posedge aclk) rst_q && !aresetn |-> !m_valid)
  else begin
    $error("m_valid high during reset");
    fail_cnt++;
  end

endmodule

bind pixel_stream_top pixel_stream_chk pixel_stream_chk_inst (
  .aclk    (aclk),
  .aresetn (aresetn),
  .s_ready (s_ready),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data)
);

// ==== sim/pixel_stream_tb.sv ====
`timescale 1ns/100ps

module pixel_stream_tb;
  import pix_pkg::*;

  localparam int N_FRAMES = 8;
  localparam int TIMEOUT  = 2000;

  logic                                aclk;
  logic                                aresetn;
  logic                                s_valid;
  logic                                s_ready;
  logic                                s_last;
  logic [IN_WORDS-1:0][WORD_WIDTH-1:0] s_data;
  logic [IN_WORDS-1:0]                 s_keep;
  logic                                m_valid;
  logic                                m_ready;
  logic [ROWS-1:0][WORD_WIDTH-1:0]     m_data;
  logic                                m_last;

  int   seed;
  int   n_checks;
  int   n_data_err;
  int   n_last_err;
  int   n_other_err;
  logic timed_out;

  // Expected output beats with the oldest first
  logic [ROWS*WORD_WIDTH-1:0] exp_data_q[$];
  bit                         exp_last_q[$];

  pixel_stream_top pixel_stream_top_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Sink back-pressure with ready high about 70 percent of cycles
  initial begin
    logic rdy_nxt;
    m_ready = 1'b0;
    @(posedge aclk);
    forever begin
      @(negedge aclk);
      rdy_nxt = ({$random(seed)} % 10) < 7;
      @(posedge aclk);
      m_ready <= rdy_nxt;
    end
  end

  task automatic check_beat();
    logic [ROWS*WORD_WIDTH-1:0] exp_d;
    bit                         exp_l;
    if (exp_data_q.size() == 0) begin
      $display("Output beat %h arrived with no beat expected", m_data);
      n_other_err++;
    end else begin
      exp_d = exp_data_q.pop_front();
      exp_l = exp_last_q.pop_front();
      n_checks++;
      if (m_data !== exp_d) begin
        $display("Fail m_data: expected %h, got %h", exp_d, m_data);
        n_data_err++;
      end
      if (m_last !== exp_l) begin
        $display("Fail m_last: expected %h, got %h", exp_l, m_last);
        n_last_err++;
      end
    end
  endtask

  // Values at the falling edge are the ones the next rising edge sees
  initial begin
    forever begin
      @(negedge aclk);
      if (aresetn && m_valid && m_ready) begin
        check_beat();
      end
    end
  end

  task automatic send_beat(input logic [31:0] data, input logic [3:0] keep, input logic last);
    int   t;
    int   idle;
    logic done;
    if (timed_out) return;
    s_valid <= 1'b0;
    idle = 0;
    while (idle < 8 && ({$random(seed)} % 10) >= 7) begin
      @(posedge aclk);
      idle++;
    end
    s_valid <= 1'b1;
    s_data  <= data;
    s_keep  <= keep;
    s_last  <= last;
    t    = 0;
    done = 1'b0;
    while (!done && t < TIMEOUT) begin
      @(negedge aclk);
      done = s_ready;
      @(posedge aclk);
      t++;
    end
    if (!done) begin
      $display("Input beat was not accepted within %0d cycles", TIMEOUT);
      n_other_err++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_frame(input int f);
    int                    kh2, ci, w, blk, per_blk, n_grp, n_words, pos, n;
    logic [WORD_WIDTH-1:0] words[$];
    logic [WORD_WIDTH-1:0] comb[6];
    logic [31:0]           beat;
    logic [31:0]           cfg_word;
    kh2     = (f < 2) ? f : {$random(seed)} % 2;
    ci      = 1 + {$random(seed)} % 3;
    w       = 1 + {$random(seed)} % 3;
    blk     = (f == 2) ? 3 : 1 + {$random(seed)} % 3;
    per_blk = ci * w;
    n_grp   = per_blk * blk;
    n_words = GRP_WORDS * n_grp;
    for (int i = 0; i < n_words; i++) begin
      words.push_back(WORD_WIDTH'($random(seed)));
    end
    // Top edge then the five group words
    for (int g = 0; g < n_grp; g++) begin
      comb[0] = (g < per_blk) ? '0 : words[(g - per_blk) * GRP_WORDS + ROWS - 1];
      for (int k = 0; k < GRP_WORDS; k++) begin
        comb[k + 1] = words[g * GRP_WORDS + k];
      end
      for (int j = 0; j <= 2 * kh2; j++) begin
        for (int r = 0; r < ROWS; r++) begin
          beat[r*WORD_WIDTH +: WORD_WIDTH] = comb[r + 1 - kh2 + j];
        end
        exp_data_q.push_back(beat);
        exp_last_q.push_back(g == n_grp - 1 && j == 2 * kh2);
      end
    end
    cfg_word = kh2 | ((ci - 1) << BITS_KH2) | ((w - 1) << (BITS_KH2 + BITS_CI)) |
               ((blk - 1) << (BITS_KH2 + BITS_CI + BITS_XW));
    send_beat(cfg_word, 4'hf, 1'b0);
    pos = 0;
    while (pos < n_words) begin
      n = (({$random(seed)} % 10) < 7) ? IN_WORDS : 1 + {$random(seed)} % 3;
      if (n > n_words - pos) n = n_words - pos;
      // Dropped lanes carry junk
      beat = $random(seed);
      for (int i = 0; i < n; i++) begin
        beat[i*WORD_WIDTH +: WORD_WIDTH] = words[pos + i];
      end
      send_beat(beat, 4'((1 << n) - 1), (pos + n) == n_words);
      pos = pos + n;
    end
  endtask

  initial begin
    int t;
    int n_assert;
    seed        = 32'hbc27;
    n_checks    = 0;
    n_data_err  = 0;
    n_last_err  = 0;
    n_other_err = 0;
    timed_out   = 1'b0;
    aresetn     = 1'b0;
    s_valid     = 1'b0;
    s_last      = 1'b0;
    s_data      = '0;
    s_keep      = '0;
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    for (int f = 0; f < N_FRAMES && !timed_out; f++) begin
      run_frame(f);
    end
    s_valid <= 1'b0;
    t = 0;
    while (!timed_out && exp_data_q.size() != 0 && t < TIMEOUT) begin
      @(posedge aclk);
      t++;
    end
    if (exp_data_q.size() != 0) begin
      $display("%0d output beats never arrived", exp_data_q.size());
      n_other_err++;
    end
    // Catch any stray beats after the last frame
    repeat (20) @(posedge aclk);
    n_assert = pixel_stream_top_inst.pixel_stream_chk_inst.fail_cnt;
    $write("Checked %0d beats: data errors %0d, last errors %0d, ",
           n_checks, n_data_err, n_last_err);
    $display("other errors %0d, assertion failures %0d", n_other_err, n_assert);
    if (n_data_err + n_last_err + n_other_err + n_assert == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
src/pix_pkg.sv
src/pix_if.sv
src/word_packer.sv
src/pix_ctrl.sv
src/edge_ram.sv
src/row_shifter.sv
src/pixel_stream_top.sv
sim/pixel_stream_chk.sv
sim/pixel_stream_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module pixel_stream_tb \
  -f flist.f -Mdir obj_dir -o sim_pixel_stream
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_pixel_stream +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
